// ==== hdl/icache_cfg.svh ====
// ---------------------------------------
// Instruction cache configuration
// Sizes of the fetch port, lines and refill queue
// ---------------------------------------
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Fetch port
`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32
`define ICACHE_ID_W        4

// Cache geometry, 64 direct mapped lines of 4 words
`define ICACHE_LINE_WORDS  4
`define ICACHE_INDEX_W     6

// Refills that may be in flight at once
`define ICACHE_QUEUE_DEPTH 4

`endif

// ==== hdl/icache_pkg.sv ====
// ---------------------------------------
// Instruction cache shared types
// Address fields, line storage and refill records
// ---------------------------------------
`include "icache_cfg.svh"

package icache_pkg;

  localparam int BYTE_W   = $clog2(`ICACHE_WORD_W / 8);
  localparam int OFFSET_W = $clog2(`ICACHE_LINE_WORDS);
  localparam int LINE_LSB = OFFSET_W + BYTE_W;              // First index bit
  localparam int TAG_W    = `ICACHE_ADDR_W - `ICACHE_INDEX_W - LINE_LSB;
  localparam int N_LINES  = 1 << `ICACHE_INDEX_W;

  typedef logic [`ICACHE_ADDR_W-1:0]  addr_t;
  typedef logic [`ICACHE_WORD_W-1:0]  word_t;
  typedef logic [`ICACHE_ID_W-1:0]    fetch_id_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0]           tag_t;
  typedef logic [OFFSET_W-1:0]        offset_t;

  typedef word_t [`ICACHE_LINE_WORDS-1:0] line_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  // One outstanding refill and the fetch that caused it
  typedef struct packed {
    fetch_id_t id;
    offset_t   offset;
    tag_t      tag;
    index_t    index;
  } refill_rec_t;

  // --------------------------------------
  // Address field helpers
  // --------------------------------------
  function automatic index_t addr_index(addr_t addr);
    return addr[LINE_LSB +: `ICACHE_INDEX_W];
  endfunction

  function automatic tag_t addr_tag(addr_t addr);
    return addr[`ICACHE_ADDR_W-1 -: TAG_W];
  endfunction

  function automatic offset_t addr_offset(addr_t addr);
    return addr[BYTE_W +: OFFSET_W];
  endfunction

  function automatic addr_t line_addr(addr_t addr);
    return {addr[`ICACHE_ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
  endfunction

endpackage

// ==== hdl/line_ram.sv ====
`timescale 1ns/1ps
// ---------------------------------------
// Single port line RAM
// One read or write per cycle, registered read data
// ---------------------------------------
module line_ram import icache_pkg::*; #(
  parameter int  DEPTH   = N_LINES,
  parameter type entry_t = line_t
) (
  input  logic   clk,
  input  logic   req_i,
  input  logic   we_i,
  input  index_t addr_i,
  input  entry_t wdata_i,
  output entry_t rdata_o
);

  entry_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (req_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];       // Held until the next read
      end
    end
  end

endmodule

// ==== hdl/lookup_pipe.sv ====
`timescale 1ns/1ps
// ---------------------------------------
// Lookup stage 1
// Holds the fetch, compares the tag, picks the word
// ---------------------------------------
module lookup_pipe import icache_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       advance_i,
  input  logic       clear_i,
  input  logic       req_i,
  input  addr_t      addr_i,
  input  fetch_id_t  id_i,
  input  tag_entry_t tag_entry_i,
  input  line_t      line_i,
  output logic       s1_valid_o,
  output logic       s1_hit_o,
  output addr_t      s1_addr_o,
  output fetch_id_t  s1_id_o,
  output word_t      s1_word_o
);

  logic      s1_valid_q;
  addr_t     s1_addr_q;
  fetch_id_t s1_id_q;
  logic      tag_match;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
    end else if (clear_i) begin
      s1_valid_q <= 1'b0;
    end else if (advance_i) begin
      s1_valid_q <= req_i;            // Empty slot when nothing is fetched
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i) begin
      s1_addr_q <= addr_i;
      s1_id_q   <= id_i;
    end
  end

  // Tag RAM output belongs to the stage 1 address
  assign tag_match = tag_entry_i.valid && (tag_entry_i.tag == addr_tag(s1_addr_q));

  assign s1_valid_o = s1_valid_q;
  assign s1_hit_o   = s1_valid_q && tag_match;
  assign s1_addr_o  = s1_addr_q;
  assign s1_id_o    = s1_id_q;
  assign s1_word_o  = line_i[addr_offset(s1_addr_q)];

endmodule

// ==== hdl/refill_queue.sv ====
`timescale 1ns/1ps
// ---------------------------------------
// Refill queue
// In order list of pending refills with a line lookup
// ---------------------------------------
`include "icache_cfg.svh"

module refill_queue import icache_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        push_i,
  input  refill_rec_t push_rec_i,
  input  logic        pop_i,
  output refill_rec_t head_rec_o,
  output logic        empty_o,
  output logic        full_o,
  input  tag_t        check_tag_i,
  input  index_t      check_index_i,
  output logic        pending_match_o
);

  localparam int DEPTH = `ICACHE_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  refill_rec_t      recs [DEPTH];
  logic [DEPTH-1:0] vld_q;
  logic [DEPTH-1:0] hit_vec;
  ptr_t             wr_ptr_q;
  ptr_t             rd_ptr_q;

  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        vld_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q        <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        vld_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q        <= ptr_inc(rd_ptr_q);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      recs[wr_ptr_q] <= push_rec_i;
    end
  end

  assign head_rec_o = recs[rd_ptr_q];
  assign empty_o    = !vld_q[rd_ptr_q];
  assign full_o     = vld_q[wr_ptr_q];   // Write slot still taken

  // Same line already on its way from memory
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      hit_vec[i] = vld_q[i] && (recs[i].tag == check_tag_i) &&
                   (recs[i].index == check_index_i);
    end
  end

  assign pending_match_o = |hit_vec;

  // The controller only pushes with room and pops with a record present
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_i |-> !full_o);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> !empty_o);

endmodule

// ==== hdl/cache_ctrl_fsm.sv ====
`timescale 1ns/1ps
// ---------------------------------------
// Cache controller FSM
// Sweep, lookup, refill requests and refill writes
// Picks the source of each fetch response
// ---------------------------------------
module cache_ctrl_fsm import icache_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        fetch_req_i,
  input  addr_t       fetch_addr_i,
  output logic        fetch_grant_o,
  input  logic        s1_valid_i,
  input  logic        s1_hit_i,
  input  addr_t       s1_addr_i,
  input  fetch_id_t   s1_id_i,
  input  word_t       s1_word_i,
  input  logic        pending_match_i,
  input  logic        q_empty_i,
  input  logic        q_full_i,
  input  refill_rec_t head_rec_i,
  output logic        q_push_o,
  output refill_rec_t q_push_rec_o,
  output logic        q_pop_o,
  output logic        pipe_advance_o,
  output logic        pipe_clear_o,
  output logic        ram_req_o,
  output logic        ram_we_o,
  output index_t      ram_addr_o,
  output tag_entry_t  tag_wdata_o,
  output logic        mem_ar_valid_o,
  input  logic        mem_ar_ready_i,
  output addr_t       mem_ar_addr_o,
  input  logic        mem_r_valid_i,
  output logic        mem_r_ready_o,
  input  line_t       mem_r_line_i,
  output logic        fetch_r_valid_o,
  output word_t       fetch_r_data_o,
  output fetch_id_t   fetch_r_id_o,
  input  logic        flush_req_i,
  output logic        flush_ack_o
);

  typedef enum logic [2:0] {
    SWEEP, OPERATE, REQUEST_REFILL, WAIT_PENDING, WRITE_REFILL, REPLAY_READ, REPLAY_HIT
  } state_t;

  state_t state_q;
  state_t state_d;
  index_t sweep_cnt_q;
  logic   sweep_flush_q;                 // Current sweep answers a flush
  logic   sweep_flush_d;
  logic   sweep_last;
  logic   s1_miss;

  assign sweep_last = (sweep_cnt_q == index_t'(N_LINES - 1));
  assign s1_miss    = s1_valid_i && !s1_hit_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= SWEEP;            // Invalidate everything after reset
      sweep_cnt_q   <= '0;
      sweep_flush_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      sweep_flush_q <= sweep_flush_d;
      if (state_q == SWEEP) begin
        sweep_cnt_q <= sweep_cnt_q + 1'b1; // Wraps back to 0 at the end
      end
    end
  end

  // Refill request and record come from the held stage 1 fetch
  assign mem_ar_addr_o = line_addr(s1_addr_i);
  assign q_push_rec_o  = '{id:     s1_id_i,
                           offset: addr_offset(s1_addr_i),
                           tag:    addr_tag(s1_addr_i),
                           index:  addr_index(s1_addr_i)};

  // Refill writes answer the head fetch straight from the line
  assign fetch_r_data_o = (state_q == WRITE_REFILL) ? mem_r_line_i[head_rec_i.offset] : s1_word_i;
  assign fetch_r_id_o   = (state_q == WRITE_REFILL) ? head_rec_i.id : s1_id_i;

  // --------------------------------------
  // Next state and strobes
  // --------------------------------------
  always_comb begin
    state_d         = state_q;
    sweep_flush_d   = sweep_flush_q;
    fetch_grant_o   = 1'b0;
    pipe_advance_o  = 1'b0;
    pipe_clear_o    = 1'b0;
    ram_req_o       = 1'b0;
    ram_we_o        = 1'b0;
    ram_addr_o      = addr_index(fetch_addr_i);
    tag_wdata_o     = '0;
    mem_ar_valid_o  = 1'b0;
    mem_r_ready_o   = 1'b0;
    q_push_o        = 1'b0;
    q_pop_o         = 1'b0;
    fetch_r_valid_o = 1'b0;
    flush_ack_o     = 1'b0;

    case (state_q)
      SWEEP: begin
        ram_req_o  = 1'b1;
        ram_we_o   = 1'b1;               // Tag entry with valid cleared
        ram_addr_o = sweep_cnt_q;
        if (sweep_last) begin
          flush_ack_o   = sweep_flush_q;
          sweep_flush_d = 1'b0;
          state_d       = OPERATE;
        end
      end

      OPERATE: begin
        fetch_r_valid_o = s1_hit_i;
        if (mem_r_valid_i) begin
          pipe_clear_o = s1_hit_i;       // Hit answered, a miss stays for replay
          state_d      = WRITE_REFILL;
        end else if (s1_miss) begin
          state_d = pending_match_i ? WAIT_PENDING : REQUEST_REFILL;
        end else if (flush_req_i) begin
          pipe_clear_o = 1'b1;           // Drain stage 1, no new grants
          if (!s1_valid_i && q_empty_i) begin
            sweep_flush_d = 1'b1;
            state_d       = SWEEP;
          end
        end else begin
          fetch_grant_o  = 1'b1;
          pipe_advance_o = 1'b1;
          ram_req_o      = fetch_req_i;  // Read both RAMs for stage 1
        end
      end

      REQUEST_REFILL: begin
        if (q_full_i) begin
          // No room to track it, drain a returning line first
          if (mem_r_valid_i) begin
            state_d = WRITE_REFILL;
          end
        end else begin
          mem_ar_valid_o = 1'b1;
          if (mem_ar_ready_i) begin
            q_push_o     = 1'b1;
            pipe_clear_o = 1'b1;         // Fetch now lives in the queue
            state_d      = OPERATE;
          end
        end
      end

      WAIT_PENDING: begin
        if (mem_r_valid_i) begin
          state_d = WRITE_REFILL;
        end
      end

      WRITE_REFILL: begin
        mem_r_ready_o   = 1'b1;
        ram_req_o       = 1'b1;
        ram_we_o        = 1'b1;
        ram_addr_o      = head_rec_i.index;
        tag_wdata_o     = '{valid: 1'b1, tag: head_rec_i.tag};
        q_pop_o         = 1'b1;
        fetch_r_valid_o = 1'b1;
        state_d         = s1_valid_i ? REPLAY_READ : OPERATE;
      end

      REPLAY_READ: begin
        ram_req_o  = 1'b1;
        ram_addr_o = addr_index(s1_addr_i);
        state_d    = REPLAY_HIT;
      end

      REPLAY_HIT: begin
        if (s1_hit_i) begin
          fetch_r_valid_o = 1'b1;
          pipe_clear_o    = 1'b1;
          state_d         = OPERATE;
        end else begin
          state_d = pending_match_i ? WAIT_PENDING : REQUEST_REFILL;
        end
      end

      default: begin
        state_d = SWEEP;
      end
    endcase
  end

  // A grant only comes with the sweep counter wrapped and no flush sweep open
  a_no_grant_sweep: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_grant_o |-> (sweep_cnt_q == '0) && !sweep_flush_q);

endmodule

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ps
// ---------------------------------------
// Instruction cache top
// Direct mapped, non-blocking line refills
// ---------------------------------------
module icache_top import icache_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Fetch port
  input  logic      fetch_req_i,
  output logic      fetch_grant_o,
  input  addr_t     fetch_addr_i,
  input  fetch_id_t fetch_id_i,
  output logic      fetch_r_valid_o,
  output word_t     fetch_r_data_o,
  output fetch_id_t fetch_r_id_o,
  // Memory read port
  output logic      mem_ar_valid_o,
  input  logic      mem_ar_ready_i,
  output addr_t     mem_ar_addr_o,
  input  logic      mem_r_valid_i,
  output logic      mem_r_ready_o,
  input  line_t     mem_r_line_i,
  // Flush
  input  logic      flush_req_i,
  output logic      flush_ack_o
);

  logic        s1_valid;
  logic        s1_hit;
  addr_t       s1_addr;
  fetch_id_t   s1_id;
  word_t       s1_word;
  logic        pipe_advance;
  logic        pipe_clear;
  logic        ram_req;
  logic        ram_we;
  index_t      ram_addr;
  tag_entry_t  tag_wdata;
  tag_entry_t  tag_rdata;
  line_t       line_rdata;
  logic        q_push;
  refill_rec_t q_push_rec;
  logic        q_pop;
  refill_rec_t head_rec;
  logic        q_empty;
  logic        q_full;
  logic        pending_match;

  lookup_pipe u_pipe (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance_i   (pipe_advance),
    .clear_i     (pipe_clear),
    .req_i       (fetch_req_i),
    .addr_i      (fetch_addr_i),
    .id_i        (fetch_id_i),
    .tag_entry_i (tag_rdata),
    .line_i      (line_rdata),
    .s1_valid_o  (s1_valid),
    .s1_hit_o    (s1_hit),
    .s1_addr_o   (s1_addr),
    .s1_id_o     (s1_id),
    .s1_word_o   (s1_word)
  );

  // Checked against the line held in stage 1
  refill_queue u_queue (
    .clk             (clk),
    .rst_n           (rst_n),
    .push_i          (q_push),
    .push_rec_i      (q_push_rec),
    .pop_i           (q_pop),
    .head_rec_o      (head_rec),
    .empty_o         (q_empty),
    .full_o          (q_full),
    .check_tag_i     (addr_tag(s1_addr)),
    .check_index_i   (addr_index(s1_addr)),
    .pending_match_o (pending_match)
  );

  cache_ctrl_fsm u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_grant_o   (fetch_grant_o),
    .s1_valid_i      (s1_valid),
    .s1_hit_i        (s1_hit),
    .s1_addr_i       (s1_addr),
    .s1_id_i         (s1_id),
    .s1_word_i       (s1_word),
    .pending_match_i (pending_match),
    .q_empty_i       (q_empty),
    .q_full_i        (q_full),
    .head_rec_i      (head_rec),
    .q_push_o        (q_push),
    .q_push_rec_o    (q_push_rec),
    .q_pop_o         (q_pop),
    .pipe_advance_o  (pipe_advance),
    .pipe_clear_o    (pipe_clear),
    .ram_req_o       (ram_req),
    .ram_we_o        (ram_we),
    .ram_addr_o      (ram_addr),
    .tag_wdata_o     (tag_wdata),
    .mem_ar_valid_o  (mem_ar_valid_o),
    .mem_ar_ready_i  (mem_ar_ready_i),
    .mem_ar_addr_o   (mem_ar_addr_o),
    .mem_r_valid_i   (mem_r_valid_i),
    .mem_r_ready_o   (mem_r_ready_o),
    .mem_r_line_i    (mem_r_line_i),
    .fetch_r_valid_o (fetch_r_valid_o),
    .fetch_r_data_o  (fetch_r_data_o),
    .fetch_r_id_o    (fetch_r_id_o),
    .flush_req_i     (flush_req_i),
    .flush_ack_o     (flush_ack_o)
  );

  // Both RAMs share request, write enable and index
  line_ram #(
    .DEPTH   (N_LINES),
    .entry_t (tag_entry_t)
  ) u_tag_ram (
    .clk     (clk),
    .req_i   (ram_req),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (tag_wdata),
    .rdata_o (tag_rdata)
  );

  line_ram #(
    .DEPTH   (N_LINES),
    .entry_t (line_t)
  ) u_data_ram (
    .clk     (clk),
    .req_i   (ram_req),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .wdata_i (mem_r_line_i),
    .rdata_o (line_rdata)
  );

endmodule

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/1ps
// ---------------------------------------
// Testbench clock source
// Free running, 40 ns period
// ---------------------------------------
module tb_clkgen #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== verif/icache_tb.sv ====
`timescale 1ns/1ps
// ---------------------------------------
// Instruction cache testbench
// Random fetches against a line memory model
// Scoreboard by fetch ID, flush and refill checks
// ---------------------------------------
module icache_tb import icache_pkg::*; ();

  localparam int N_FETCHES      = 600;
  localparam int N_IDS          = 16;
  localparam int WIN_LINES      = 96;            // More lines than the cache holds
  localparam int TIMEOUT_CYCLES = N_FETCHES * 40 + 4 * N_LINES;
  localparam addr_t WIN_BASE    = 32'h0001_0000;

  logic      clk;
  logic      rst_n;
  logic      fetch_req_i;
  logic      fetch_grant_o;
  addr_t     fetch_addr_i;
  fetch_id_t fetch_id_i;
  logic      fetch_r_valid_o;
  word_t     fetch_r_data_o;
  fetch_id_t fetch_r_id_o;
  logic      mem_ar_valid_o;
  logic      mem_ar_ready_i;
  addr_t     mem_ar_addr_o;
  logic      mem_r_valid_i;
  logic      mem_r_ready_o;
  line_t     mem_r_line_i;
  logic      flush_req_i;
  logic      flush_ack_o;

  // Scoreboard, one slot per fetch ID
  bit    outstanding [N_IDS];
  addr_t fetch_addr  [N_IDS];
  int    accept_cycle[N_IDS];
  bit    expect_fast [N_IDS];
  bit    need_refill [N_IDS];

  // Lines the cache should hold, by index
  bit    res_valid[N_LINES];
  addr_t res_line [N_LINES];

  bit    pending_line[addr_t];                   // Requested, not yet returned
  bit    requested[addr_t];                      // Requested since the last flush
  bit    fetched[addr_t];                        // Fetched since the last flush
  addr_t mq_addr[$];
  int    mq_due[$];

  int cycle;
  int n_accepted;
  int n_out;
  int grant_low_run;
  bit first_grant_seen;
  bit line_taken;
  bit flush_active;
  int flush_idx;
  int flush_at[2];

  tb_clkgen u_clkgen (.clk_o(clk));

  icache_top uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .fetch_req_i     (fetch_req_i),
    .fetch_grant_o   (fetch_grant_o),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_id_i      (fetch_id_i),
    .fetch_r_valid_o (fetch_r_valid_o),
    .fetch_r_data_o  (fetch_r_data_o),
    .fetch_r_id_o    (fetch_r_id_o),
    .mem_ar_valid_o  (mem_ar_valid_o),
    .mem_ar_ready_i  (mem_ar_ready_i),
    .mem_ar_addr_o   (mem_ar_addr_o),
    .mem_r_valid_i   (mem_r_valid_i),
    .mem_r_ready_o   (mem_r_ready_o),
    .mem_r_line_i    (mem_r_line_i),
    .flush_req_i     (flush_req_i),
    .flush_ack_o     (flush_ack_o)
  );

  // --------------------------------------
  // Memory model and checks
  // --------------------------------------
  function automatic word_t model_word(addr_t a);
    return a ^ 32'h5a5a_0000;
  endfunction

  function automatic line_t model_line(addr_t base);
    line_t l;
    for (int i = 0; i < 4; i++) begin
      l[i] = model_word(base + addr_t'(4 * i));
    end
    return l;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Everything here reads values settled since the last falling edge
  task automatic sample_outputs();
    int    id;
    addr_t line;
    cycle++;
    if (cycle > TIMEOUT_CYCLES) begin
      $display("** FAIL **");
      $fatal(1, "Timeout, the cache stopped answering after %0d cycles", cycle);
    end
    if (n_accepted == 0) begin                   // Quiet memory side until the first fetch
      check_equal("mem_ar_valid_o", mem_ar_valid_o, 0);
      check_equal("mem_r_ready_o", mem_r_ready_o, 0);
    end
    if (!fetch_grant_o) begin
      grant_low_run++;
    end else begin
      if (!first_grant_seen) check_equal("fetch_grant_o low cycles", grant_low_run, N_LINES);
      first_grant_seen = 1'b1;
      grant_low_run    = 0;
    end

    if (fetch_r_valid_o) begin
      id   = fetch_r_id_o;
      line = {fetch_addr[id][31:4], 4'h0};
      check_equal("fetch_r_id_o outstanding", outstanding[id], 1);
      check_equal("fetch_r_data_o", fetch_r_data_o, model_word(fetch_addr[id]));
      if (expect_fast[id]) check_equal("fetch_r_valid_o latency", cycle - accept_cycle[id], 1);
      if (need_refill[id]) check_equal("mem_ar_addr_o refill seen", requested.exists(line), 1);
      outstanding[id] = 1'b0;
      n_out--;
    end

    if (mem_r_ready_o) begin
      check_equal("mem_r_ready_o with line offered", mem_r_valid_i, 1);
      line                 = mq_addr.pop_front();
      void'(mq_due.pop_front());
      res_valid[line[9:4]] = 1'b1;
      res_line[line[9:4]]  = line;
      pending_line.delete(line);
      line_taken           = 1'b1;
    end

    if (mem_ar_valid_o && mem_ar_ready_i) begin
      check_equal("mem_ar_addr_o alignment", mem_ar_addr_o[3:0], 0);
      check_equal("mem_ar_addr_o duplicate", pending_line.exists(mem_ar_addr_o), 0);
      pending_line[mem_ar_addr_o] = 1'b1;
      requested[mem_ar_addr_o]    = 1'b1;
      mq_addr.push_back(mem_ar_addr_o);
      mq_due.push_back(cycle + 1 + int'($urandom % 8));
    end

    if (fetch_req_i && fetch_grant_o) begin
      id               = fetch_id_i;
      line             = {fetch_addr_i[31:4], 4'h0};
      outstanding[id]  = 1'b1;
      fetch_addr[id]   = fetch_addr_i;
      accept_cycle[id] = cycle;
      expect_fast[id]  = res_valid[line[9:4]] && (res_line[line[9:4]] == line);
      need_refill[id]  = !fetched.exists(line);
      fetched[line]    = 1'b1;
      n_accepted++;
      n_out++;
    end

    if (flush_ack_o) begin
      check_equal("flush_ack_o while requested", flush_active, 1);
      check_equal("fetch_grant_o low through sweep", grant_low_run >= N_LINES, 1);
      flush_active = 1'b0;
      foreach (res_valid[i]) res_valid[i] = 1'b0;
      requested.delete();
      fetched.delete();
    end
  endtask

  task automatic drive_inputs();
    int id;
    mem_ar_ready_i = ($urandom % 3) != 0;
    if (!flush_active && flush_idx < 2 && n_accepted >= flush_at[flush_idx]) begin
      flush_active = 1'b1;
      flush_idx++;
    end
    flush_req_i = flush_active;

    fetch_req_i = 1'b0;
    if (!flush_active && n_accepted < N_FETCHES && n_out < N_IDS && ($urandom % 4) != 0) begin
      id = $urandom % N_IDS;
      while (outstanding[id]) id = (id + 1) % N_IDS;  // First free ID from a random start
      fetch_req_i  = 1'b1;
      fetch_id_i   = fetch_id_t'(id);
      fetch_addr_i = WIN_BASE + addr_t'(($urandom % WIN_LINES) * 16) + addr_t'(($urandom % 4) * 4);
    end

    if (line_taken) begin
      mem_r_valid_i = 1'b0;
      line_taken    = 1'b0;
    end
    if (!mem_r_valid_i && mq_addr.size() > 0 && mq_due[0] <= cycle) begin
      mem_r_valid_i = 1'b1;                      // Head line, held until taken
      mem_r_line_i  = model_line(mq_addr[0]);
    end
  endtask

  // --------------------------------------
  // Main sequence
  // --------------------------------------
  initial begin
    rst_n          = 1'b0;
    fetch_req_i    = 1'b0;
    fetch_addr_i   = '0;
    fetch_id_i     = '0;
    mem_ar_ready_i = 1'b0;
    mem_r_valid_i  = 1'b0;
    mem_r_line_i   = '0;
    flush_req_i    = 1'b0;
    void'($urandom(32'h8e5e_7a5f));
    flush_at[0] = 100 + int'($urandom % 200);
    flush_at[1] = 350 + int'($urandom % 200);

    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    while (!(n_accepted == N_FETCHES && n_out == 0 && flush_idx == 2 && !flush_active)) begin
      @(posedge clk);
      sample_outputs();
      @(negedge clk);
      drive_inputs();
    end

    check_equal("refills outstanding", mq_addr.size(), 0);
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/icache_pkg.sv
hdl/line_ram.sv
hdl/lookup_pipe.sv
hdl/refill_queue.sv
hdl/cache_ctrl_fsm.sv
hdl/icache_top.sv
verif/tb_clkgen.sv
verif/icache_tb.sv
